/* src/udp_echo_consts.svh */
`ifndef UDP_ECHO_CONSTS_SVH
`define UDP_ECHO_CONSTS_SVH

// Station identity
`define LOCAL_MAC 48'h02_00_00_00_00_00
`define LOCAL_IP {8'd192, 8'd168, 8'd1, 8'd128}

// UDP echo service
`define SERVICE_PORT 16'd1234
`define REPLY_TTL 8'd64

// Protocol codes
`define ETHERTYPE_IPV4 16'h0800
`define IP_PROTO_UDP 8'd17

// Header sizes in bytes, no options
`define ETH_HDR_BYTES 14
`define IP_HDR_BYTES 20
`define UDP_HDR_BYTES 8

`endif

/* src/udp_echo_pkg.sv */
package udp_echo_pkg;

  typedef logic [7:0]  byte_t;
  typedef logic [47:0] mac_addr_t;
  typedef logic [31:0] ip_addr_t;
  typedef logic [15:0] udp_port_t;
  typedef logic [15:0] len16_t;
  typedef logic [4:0]  hdr_cnt_t;

  // One byte of the frame stream, user flags a bad frame
  typedef struct packed {
    byte_t data;
    logic  last;
    logic  user;
  } stream_beat_t;

  typedef struct packed {
    ip_addr_t src_ip;
  } ip_meta_t;

  typedef struct packed {
    ip_meta_t  ip;
    udp_port_t src_port;
    udp_port_t dst_port;
    len16_t    length;
  } udp_meta_t;

  typedef struct packed {
    ip_addr_t  dest_ip;
    ip_addr_t  source_ip;
    byte_t     ttl;
    udp_port_t src_port;
    udp_port_t dst_port;
    len16_t    length;
    logic [15:0] checksum;
  } reply_hdr_t;

  typedef enum logic [1:0] {HDR, PASS, DROP} parse_state_t;

  typedef enum logic [1:0] {IDLE, FWD, DISCARD} filt_state_t;

endpackage

/* src/eth_hdr_parser.sv */
`timescale 1ns/1ps
`include "udp_echo_consts.svh"

module eth_hdr_parser (
  input  logic                       clk,
  input  logic                       rst,
  input  udp_echo_pkg::stream_beat_t s_beat,
  input  logic                       s_valid,
  output logic                       s_ready,
  output udp_echo_pkg::stream_beat_t m_beat,
  output logic                       m_valid,
  input  logic                       m_ready
);
  import udp_echo_pkg::*;

  parse_state_t state;
  hdr_cnt_t     cnt;
  mac_addr_t    dst_mac;
  byte_t        type_hi;
  logic         armed;
  logic         s_fire;
  logic         hdr_end;
  logic         hdr_ok;

  // A held last beat blocks the next frame until it drains
  assign s_ready = armed && ((state != PASS) || !m_valid || (m_ready && !m_beat.last));
  assign s_fire  = s_valid && s_ready;
  assign hdr_end = (cnt == hdr_cnt_t'(`ETH_HDR_BYTES - 1));
  // EtherType low byte is still on the input at the header end
  assign hdr_ok  = (dst_mac == `LOCAL_MAC) && ({type_hi, s_beat.data} == `ETHERTYPE_IPV4);

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= HDR;
      cnt     <= '0;
      m_valid <= 1'b0;
      armed   <= 1'b0;
    end else begin
      armed <= 1'b1;
      if (m_valid && m_ready) begin
        m_valid <= 1'b0;
      end
      case (state)
        HDR: begin
          if (s_fire) begin
            if (s_beat.last) begin
              cnt <= '0;
            end else if (hdr_end) begin
              cnt   <= '0;
              state <= hdr_ok ? PASS : DROP;
            end else begin
              cnt <= cnt + 1'b1;
            end
          end
        end
        PASS: begin
          if (s_fire) begin
            m_valid <= 1'b1;
          end
          if (m_valid && m_ready && m_beat.last) begin
            state <= HDR;
          end
        end
        DROP: begin
          if (s_fire && s_beat.last) begin
            state <= HDR;
          end
        end
        default: state <= HDR;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == PASS && s_fire) begin
      m_beat <= s_beat;
    end
    // Destination MAC is the first six bytes
    if (state == HDR && s_fire && cnt < 5'd6) begin
      dst_mac <= {dst_mac[39:0], s_beat.data};
    end
    if (state == HDR && s_fire && cnt == 5'd12) begin
      type_hi <= s_beat.data;
    end
  end

  // Output register only ever fills inside a frame's payload
  assert property (@(posedge clk) disable iff (rst) (state == HDR) |-> !m_valid);

endmodule

/* src/ipv4_hdr_parser.sv */
`timescale 1ns/1ps
`include "udp_echo_consts.svh"

module ipv4_hdr_parser (
  input  logic                       clk,
  input  logic                       rst,
  input  udp_echo_pkg::stream_beat_t s_beat,
  input  logic                       s_valid,
  output logic                       s_ready,
  output udp_echo_pkg::stream_beat_t m_beat,
  output logic                       m_valid,
  input  logic                       m_ready,
  output udp_echo_pkg::ip_meta_t     ip_meta
);
  import udp_echo_pkg::*;

  parse_state_t state;
  hdr_cnt_t     cnt;
  byte_t        ver_ihl;
  byte_t        proto;
  ip_addr_t     src_ip;
  logic [23:0]  dst_hi;
  logic         s_fire;
  logic         hdr_end;
  logic         hdr_ok;

  assign s_ready = (state != PASS) || !m_valid || (m_ready && !m_beat.last);
  assign s_fire  = s_valid && s_ready;
  assign hdr_end = (cnt == hdr_cnt_t'(`IP_HDR_BYTES - 1));
  // Version 4 with IHL 5, UDP, addressed to us
  assign hdr_ok  = (ver_ihl == 8'h45) && (proto == `IP_PROTO_UDP) &&
                   ({dst_hi, s_beat.data} == `LOCAL_IP);

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= HDR;
      cnt     <= '0;
      m_valid <= 1'b0;
    end else begin
      if (m_valid && m_ready) begin
        m_valid <= 1'b0;
      end
      case (state)
        HDR: begin
          if (s_fire) begin
            if (s_beat.last) begin
              cnt <= '0;
            end else if (hdr_end) begin
              cnt   <= '0;
              state <= hdr_ok ? PASS : DROP;
            end else begin
              cnt <= cnt + 1'b1;
            end
          end
        end
        PASS: begin
          if (s_fire) begin
            m_valid <= 1'b1;
          end
          if (m_valid && m_ready && m_beat.last) begin
            state <= HDR;
          end
        end
        DROP: begin
          if (s_fire && s_beat.last) begin
            state <= HDR;
          end
        end
        default: state <= HDR;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == PASS && s_fire) begin
      m_beat <= s_beat;
    end
    if (state == HDR && s_fire) begin
      if (cnt == 5'd0) begin
        ver_ihl <= s_beat.data;
      end
      if (cnt == 5'd9) begin
        proto <= s_beat.data;
      end
      if (cnt >= 5'd12 && cnt <= 5'd15) begin
        src_ip <= {src_ip[23:0], s_beat.data};
      end
      if (cnt >= 5'd16 && cnt <= 5'd18) begin
        dst_hi <= {dst_hi[15:0], s_beat.data};
      end
      // Held until the next header completes
      if (hdr_end && !s_beat.last) begin
        ip_meta.src_ip <= src_ip;
      end
    end
  end

  assert property (@(posedge clk) disable iff (rst) cnt <= hdr_cnt_t'(`IP_HDR_BYTES));

endmodule

/* src/udp_hdr_parser.sv */
`timescale 1ns/1ps
`include "udp_echo_consts.svh"

module udp_hdr_parser (
  input  logic                       clk,
  input  logic                       rst,
  input  udp_echo_pkg::stream_beat_t s_beat,
  input  logic                       s_valid,
  output logic                       s_ready,
  output udp_echo_pkg::stream_beat_t m_beat,
  output logic                       m_valid,
  input  logic                       m_ready,
  input  udp_echo_pkg::ip_meta_t     ip_meta,
  output udp_echo_pkg::udp_meta_t    udp_meta
);
  import udp_echo_pkg::*;

  parse_state_t state;
  hdr_cnt_t     cnt;
  ip_meta_t     ip_cap;
  logic [47:0]  fields;
  logic         s_fire;
  logic         hdr_end;

  assign s_ready = (state != PASS) || !m_valid || (m_ready && !m_beat.last);
  assign s_fire  = s_valid && s_ready;
  assign hdr_end = (cnt == hdr_cnt_t'(`UDP_HDR_BYTES - 1));

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= HDR;
      cnt     <= '0;
      m_valid <= 1'b0;
    end else begin
      if (m_valid && m_ready) begin
        m_valid <= 1'b0;
      end
      case (state)
        HDR: begin
          if (s_fire) begin
            if (s_beat.last) begin
              cnt <= '0;
            end else if (hdr_end) begin
              cnt   <= '0;
              state <= PASS;
            end else begin
              cnt <= cnt + 1'b1;
            end
          end
        end
        PASS: begin
          if (s_fire) begin
            m_valid <= 1'b1;
          end
          if (m_valid && m_ready && m_beat.last) begin
            state <= HDR;
          end
        end
        default: state <= HDR;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == PASS && s_fire) begin
      m_beat <= s_beat;
    end
    if (state == HDR && s_fire) begin
      // First UDP byte is the IPv4 stage's first payload beat
      if (cnt == 5'd0) begin
        ip_cap <= ip_meta;
      end
      // Ports then length, checksum ignored
      if (cnt < 5'd6) begin
        fields <= {fields[39:0], s_beat.data};
      end
      if (hdr_end && !s_beat.last) begin
        udp_meta <= '{ip: ip_cap, src_port: fields[47:32], dst_port: fields[31:16],
                      length: fields[15:0]};
      end
    end
  end

endmodule

/* src/udp_port_filter.sv */
`timescale 1ns/1ps
`include "udp_echo_consts.svh"

module udp_port_filter (
  input  logic                       clk,
  input  logic                       rst,
  input  udp_echo_pkg::stream_beat_t s_beat,
  input  logic                       s_valid,
  output logic                       s_ready,
  input  udp_echo_pkg::udp_meta_t    udp_meta,
  output udp_echo_pkg::stream_beat_t m_beat,
  output logic                       m_valid,
  input  logic                       m_ready,
  output udp_echo_pkg::reply_hdr_t   reply_hdr,
  output logic                       reply_valid,
  input  logic                       reply_ready,
  output udp_echo_pkg::byte_t        led
);
  import udp_echo_pkg::*;

  filt_state_t state;
  logic        first_pend;
  logic        port_hit;
  logic        s_fire;

  assign port_hit = (udp_meta.dst_port == `SERVICE_PORT);
  // Nothing is taken in IDLE; the first beat waits for the reply handshake
  assign s_ready  = (state == DISCARD) ||
                    ((state == FWD) && (!m_valid || (m_ready && !m_beat.last)));
  assign s_fire   = s_valid && s_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= IDLE;
      m_valid     <= 1'b0;
      reply_valid <= 1'b0;
      first_pend  <= 1'b0;
      led         <= '0;
    end else begin
      if (m_valid && m_ready) begin
        m_valid <= 1'b0;
        if (first_pend) begin
          led        <= m_beat.data;
          first_pend <= 1'b0;
        end
      end
      case (state)
        IDLE: begin
          if (reply_valid) begin
            if (reply_ready) begin
              reply_valid <= 1'b0;
              first_pend  <= 1'b1;
              state       <= FWD;
            end
          end else if (s_valid) begin
            if (port_hit) begin
              reply_valid <= 1'b1;
            end else begin
              state <= DISCARD;
            end
          end
        end
        FWD: begin
          if (s_fire) begin
            m_valid <= 1'b1;
          end
          if (m_valid && m_ready && m_beat.last) begin
            state <= IDLE;
          end
        end
        DISCARD: begin
          if (s_fire && s_beat.last) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == FWD && s_fire) begin
      m_beat <= s_beat;
    end
    // Swap ports and turn the datagram back to its sender
    if (state == IDLE && !reply_valid && s_valid && port_hit) begin
      reply_hdr <= '{dest_ip: udp_meta.ip.src_ip, source_ip: `LOCAL_IP, ttl: `REPLY_TTL,
                     src_port: udp_meta.dst_port, dst_port: udp_meta.src_port,
                     length: udp_meta.length, checksum: 16'h0000};
    end
  end

  assert property (@(posedge clk) disable iff (rst)
    reply_valid && !reply_ready |=> reply_valid && $stable(reply_hdr));

endmodule

/* src/udp_echo_top.sv */
`timescale 1ns/1ps

module udp_echo_top (
  input  logic                       clk,
  input  logic                       rst,
  input  udp_echo_pkg::stream_beat_t in_beat,
  input  logic                       in_valid,
  output logic                       in_ready,
  output udp_echo_pkg::stream_beat_t out_beat,
  output logic                       out_valid,
  input  logic                       out_ready,
  output udp_echo_pkg::reply_hdr_t   reply_hdr,
  output logic                       reply_valid,
  input  logic                       reply_ready,
  output udp_echo_pkg::byte_t        led
);
  import udp_echo_pkg::*;

  // Ethernet payload into IPv4 stage
  stream_beat_t eth_beat;
  logic         eth_valid;
  logic         eth_ready;

  // IPv4 payload into UDP stage
  stream_beat_t ip_beat;
  logic         ip_valid;
  logic         ip_ready;
  ip_meta_t     ip_meta;

  // UDP payload into port filter
  stream_beat_t udp_beat;
  logic         udp_valid;
  logic         udp_ready;
  udp_meta_t    udp_meta;

  eth_hdr_parser u_eth (
    .clk     (clk),
    .rst     (rst),
    .s_beat  (in_beat),
    .s_valid (in_valid),
    .s_ready (in_ready),
    .m_beat  (eth_beat),
    .m_valid (eth_valid),
    .m_ready (eth_ready)
  );

  ipv4_hdr_parser u_ip (
    .clk     (clk),
    .rst     (rst),
    .s_beat  (eth_beat),
    .s_valid (eth_valid),
    .s_ready (eth_ready),
    .m_beat  (ip_beat),
    .m_valid (ip_valid),
    .m_ready (ip_ready),
    .ip_meta (ip_meta)
  );

  udp_hdr_parser u_udp (
    .clk      (clk),
    .rst      (rst),
    .s_beat   (ip_beat),
    .s_valid  (ip_valid),
    .s_ready  (ip_ready),
    .m_beat   (udp_beat),
    .m_valid  (udp_valid),
    .m_ready  (udp_ready),
    .ip_meta  (ip_meta),
    .udp_meta (udp_meta)
  );

  udp_port_filter u_filt (
    .clk         (clk),
    .rst         (rst),
    .s_beat      (udp_beat),
    .s_valid     (udp_valid),
    .s_ready     (udp_ready),
    .udp_meta    (udp_meta),
    .m_beat      (out_beat),
    .m_valid     (out_valid),
    .m_ready     (out_ready),
    .reply_hdr   (reply_hdr),
    .reply_valid (reply_valid),
    .reply_ready (reply_ready),
    .led         (led)
  );

endmodule

/* sim/tb_udp_echo_tasks.svh */
`ifndef TB_UDP_ECHO_TASKS_SVH
`define TB_UDP_ECHO_TASKS_SVH

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Verification failed");
    $fatal(1, "Run stopped at the first failure");
  endtask

  task automatic check_beat(input string name, input stream_beat_t exp,
                            input stream_beat_t got);
    if (got !== exp) begin
      abort_run($sformatf("ERROR at time %0t: %s expected %h got %h", $time, name, exp, got));
    end
  endtask

  task automatic check_reply(input string name, input reply_hdr_t exp, input reply_hdr_t got);
    if (got !== exp) begin
      abort_run($sformatf("ERROR at time %0t: %s expected %h got %h", $time, name, exp, got));
    end
  endtask

  task automatic check_led(input string name, input byte_t exp, input byte_t got);
    if (got !== exp) begin
      abort_run($sformatf("ERROR at time %0t: %s expected %h got %h", $time, name, exp, got));
    end
  endtask

  // One byte per beat; last and the optional user flag go on the final byte
  task automatic drive_frame(input logic bad);
    int i;
    int cycles;
    for (i = 0; i < frame_q.size(); i++) begin
      in_beat.data = frame_q[i];
      in_beat.last = (i == frame_q.size() - 1);
      in_beat.user = bad && in_beat.last;
      in_valid     = 1'b1;
      cycles       = 0;
      @(negedge clk);
      while (!in_ready) begin
        cycles++;
        if (cycles > TIMEOUT_CYCLES) begin
          abort_run("Timeout: in_ready stayed low while a frame byte was offered");
        end
        @(negedge clk);
      end
      @(posedge clk);
      #1;
    end
    in_valid = 1'b0;
    in_beat  = '0;
  endtask

  // Mode flags change mid-cycle so the ready driver picks them up cleanly
  task automatic set_ready_mode(input logic rnd, input logic hold);
    @(negedge clk);
    rand_mode  = rnd;
    hold_reply = hold;
    @(posedge clk);
    #1;
  endtask

  task automatic await_reply();
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!reply_valid) begin
      cycles++;
      if (cycles > TIMEOUT_CYCLES) begin
        abort_run("Timeout: the DUT never offered a reply header");
      end
      @(negedge clk);
    end
    @(posedge clk);
    #1;
  endtask

  // Waits for everything expected so far, then checks it in order
  task automatic compare_outputs();
    int           cycles;
    stream_beat_t exp_b;
    stream_beat_t got_b;
    reply_hdr_t   exp_r;
    reply_hdr_t   got_r;
    cycles = 0;
    while (got_beats.size() < exp_beats.size() || got_replies.size() < exp_replies.size()) begin
      @(posedge clk);
      #1;
      cycles++;
      if (cycles > TIMEOUT_CYCLES) begin
        abort_run("Timeout: expected reply headers or payload never came out");
      end
    end
    while (exp_replies.size() > 0) begin
      exp_r = exp_replies.pop_front();
      got_r = got_replies.pop_front();
      check_reply("reply_hdr", exp_r, got_r);
    end
    while (exp_beats.size() > 0) begin
      exp_b = exp_beats.pop_front();
      got_b = got_beats.pop_front();
      check_beat("out_beat", exp_b, got_b);
    end
    check_led("led", exp_led, led);
  endtask

`endif

/* sim/tb_udp_echo.sv */
`timescale 1ns/1ps
`include "udp_echo_consts.svh"

module tb_udp_echo;
  import udp_echo_pkg::*;

  localparam int        TIMEOUT_CYCLES = 3000;
  localparam mac_addr_t PEER_MAC       = 48'h00_1a_2b_3c_4d_5e;
  localparam ip_addr_t  PEER_IP        = {8'd192, 8'd168, 8'd1, 8'd20};
  localparam ip_addr_t  OTHER_IP       = {8'd10, 8'd0, 8'd0, 8'd9};

  logic         clk;
  logic         rst;
  stream_beat_t in_beat;
  logic         in_valid;
  logic         in_ready;
  stream_beat_t out_beat;
  logic         out_valid;
  logic         out_ready;
  reply_hdr_t   reply_hdr;
  logic         reply_valid;
  logic         reply_ready;
  byte_t        led;

  logic   rand_mode  = 1'b0;
  logic   hold_reply = 1'b0;
  integer seed       = 32'hc349_8ae3;

  byte_t        pay_q[$];
  byte_t        frame_q[$];
  stream_beat_t exp_beats[$];
  stream_beat_t got_beats[$];
  reply_hdr_t   exp_replies[$];
  reply_hdr_t   got_replies[$];
  byte_t        exp_led;

  udp_echo_top u_dut (
    .clk         (clk),
    .rst         (rst),
    .in_beat     (in_beat),
    .in_valid    (in_valid),
    .in_ready    (in_ready),
    .out_beat    (out_beat),
    .out_valid   (out_valid),
    .out_ready   (out_ready),
    .reply_hdr   (reply_hdr),
    .reply_valid (reply_valid),
    .reply_ready (reply_ready),
    .led         (led)
  );

  `include "tb_udp_echo_tasks.svh"

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Ready lines move 1 ns after the rising edge
  initial begin
    logic [31:0] rnd;
    out_ready   = 1'b0;
    reply_ready = 1'b0;
    forever begin
      @(posedge clk);
      #1;
      if (rand_mode) begin
        rnd         = $random(seed);
        out_ready   = rnd[0];
        reply_ready = rnd[5] && !hold_reply;
      end else begin
        out_ready   = 1'b1;
        reply_ready = !hold_reply;
      end
    end
  end

  // Transfers are recorded mid-cycle, ahead of the edge that completes them
  initial begin
    forever begin
      @(negedge clk);
      if (!rst && out_valid && out_ready) begin
        got_beats.push_back(out_beat);
      end
      if (!rst && reply_valid && reply_ready) begin
        got_replies.push_back(reply_hdr);
      end
    end
  end

  task automatic put_bytes(input logic [47:0] value, input int count);
    int k;
    for (k = count - 1; k >= 0; k--) begin
      frame_q.push_back(value[8*k +: 8]);
    end
  endtask

  task automatic make_payload(input int len);
    logic [31:0] rnd;
    int          k;
    pay_q.delete();
    for (k = 0; k < len; k++) begin
      rnd = $random(seed);
      pay_q.push_back(rnd[7:0]);
    end
  endtask

  // Ethernet, IPv4 and UDP headers in front of pay_q
  task automatic build_frame(input ip_addr_t src_ip, input ip_addr_t dst_ip,
                             input udp_port_t src_port, input udp_port_t dst_port,
                             input mac_addr_t dst_mac, input logic [15:0] eth_type,
                             input byte_t ver_ihl, input byte_t proto);
    int k;
    frame_q.delete();
    put_bytes(dst_mac, 6);
    put_bytes(PEER_MAC, 6);
    put_bytes(48'(eth_type), 2);
    frame_q.push_back(ver_ihl);
    frame_q.push_back(8'h00);
    put_bytes(48'(28 + pay_q.size()), 2);
    // Identification 0, DF set
    put_bytes(48'h0000_4000, 4);
    frame_q.push_back(8'd64);
    frame_q.push_back(proto);
    put_bytes(48'h0, 2);
    put_bytes(48'(src_ip), 4);
    put_bytes(48'(dst_ip), 4);
    put_bytes(48'(src_port), 2);
    put_bytes(48'(dst_port), 2);
    put_bytes(48'(8 + pay_q.size()), 2);
    put_bytes(48'h0, 2);
    for (k = 0; k < pay_q.size(); k++) begin
      frame_q.push_back(pay_q[k]);
    end
  endtask

  task automatic build_udp(input ip_addr_t src_ip, input udp_port_t src_port,
                           input udp_port_t dst_port);
    build_frame(src_ip, `LOCAL_IP, src_port, dst_port, `LOCAL_MAC, `ETHERTYPE_IPV4,
                8'h45, `IP_PROTO_UDP);
  endtask

  // Reply goes back to the sender with ports swapped, payload is echoed as is
  task automatic expect_echo(input ip_addr_t peer_ip, input udp_port_t peer_port,
                             input logic bad);
    reply_hdr_t   r;
    stream_beat_t b;
    int           k;
    r.dest_ip   = peer_ip;
    r.source_ip = `LOCAL_IP;
    r.ttl       = `REPLY_TTL;
    r.src_port  = `SERVICE_PORT;
    r.dst_port  = peer_port;
    r.length    = len16_t'(`UDP_HDR_BYTES + pay_q.size());
    r.checksum  = 16'h0000;
    exp_replies.push_back(r);
    for (k = 0; k < pay_q.size(); k++) begin
      b.data = pay_q[k];
      b.last = (k == pay_q.size() - 1);
      b.user = bad && b.last;
      exp_beats.push_back(b);
    end
    exp_led = pay_q[0];
  endtask

  task automatic apply_reset();
    rst = 1'b1;
    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;
    if (in_ready || out_valid || reply_valid) begin
      abort_run("in_ready, out_valid or reply_valid was high right after reset");
    end
    check_led("led", 8'h00, led);
  endtask

  task automatic echo_one_datagram();
    make_payload(6);
    build_udp(PEER_IP, 16'd5000, `SERVICE_PORT);
    expect_echo(PEER_IP, 16'd5000, 1'b0);
    drive_frame(1'b0);
    compare_outputs();
  endtask

  task automatic skip_other_port();
    byte_t led_before;
    led_before = exp_led;
    set_ready_mode(1'b0, 1'b1);
    make_payload(5);
    build_udp(PEER_IP, 16'd5001, 16'd7);
    drive_frame(1'b0);
    // Three bytes fit in the stage registers while the reply is held
    make_payload(3);
    build_udp(PEER_IP, 16'd5001, `SERVICE_PORT);
    expect_echo(PEER_IP, 16'd5001, 1'b0);
    drive_frame(1'b0);
    await_reply();
    check_led("led", led_before, led);
    set_ready_mode(1'b0, 1'b0);
    compare_outputs();
  endtask

  task automatic send_dropped(input mac_addr_t dst_mac, input logic [15:0] eth_type,
                              input byte_t ver_ihl, input byte_t proto, input ip_addr_t dst_ip);
    make_payload(4);
    build_frame(PEER_IP, dst_ip, 16'd5002, `SERVICE_PORT, dst_mac, eth_type, ver_ihl, proto);
    drive_frame(1'b0);
  endtask

  task automatic drop_bad_frames();
    send_dropped(48'h02_00_00_00_00_01, `ETHERTYPE_IPV4, 8'h45, `IP_PROTO_UDP, `LOCAL_IP);
    send_dropped(`LOCAL_MAC, 16'h86dd, 8'h45, `IP_PROTO_UDP, `LOCAL_IP);
    send_dropped(`LOCAL_MAC, `ETHERTYPE_IPV4, 8'h45, 8'd6, `LOCAL_IP);
    send_dropped(`LOCAL_MAC, `ETHERTYPE_IPV4, 8'h46, `IP_PROTO_UDP, `LOCAL_IP);
    send_dropped(`LOCAL_MAC, `ETHERTYPE_IPV4, 8'h45, `IP_PROTO_UDP,
                 {8'd192, 8'd168, 8'd1, 8'd77});
    make_payload(7);
    build_udp(PEER_IP, 16'd5003, `SERVICE_PORT);
    expect_echo(PEER_IP, 16'd5003, 1'b0);
    drive_frame(1'b0);
    compare_outputs();
  endtask

  task automatic stress_random_ready();
    make_payload(64);
    build_udp(OTHER_IP, 16'd40000, `SERVICE_PORT);
    expect_echo(OTHER_IP, 16'd40000, 1'b1);
    set_ready_mode(1'b1, 1'b0);
    drive_frame(1'b1);
    compare_outputs();
    set_ready_mode(1'b0, 1'b0);
  endtask

  task automatic run_back_to_back();
    make_payload(5);
    build_udp(PEER_IP, 16'd5004, `SERVICE_PORT);
    expect_echo(PEER_IP, 16'd5004, 1'b0);
    drive_frame(1'b0);
    make_payload(9);
    build_udp(OTHER_IP, 16'd6100, `SERVICE_PORT);
    expect_echo(OTHER_IP, 16'd6100, 1'b0);
    drive_frame(1'b0);
    compare_outputs();
  endtask

  initial begin
    rst      = 1'b1;
    in_valid = 1'b0;
    in_beat  = '0;
    exp_led  = '0;
    apply_reset();
    echo_one_datagram();
    skip_other_port();
    drop_bad_frames();
    stress_random_ready();
    run_back_to_back();
    if (got_beats.size() == 0 && got_replies.size() == 0) begin
      $display("Verification passed");
      $finish;
    end else begin
      $display("The DUT produced output that no test expected");
      $display("Verification failed");
      $fatal(1, "Unexpected DUT output");
    end
  end

endmodule

/* build.f */
+incdir+src
+incdir+sim
src/udp_echo_pkg.sv
src/eth_hdr_parser.sv
src/ipv4_hdr_parser.sv
src/udp_hdr_parser.sv
src/udp_port_filter.sv
src/udp_echo_top.sv
sim/tb_udp_echo.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 \
  --timescale 1ns/1ps \
  --top-module tb_udp_echo \
  -f build.f \
  -o sim_udp_echo
./obj_dir/sim_udp_echo
